// ==== list.f ====
lcd_timing_pkg.sv
lcd_cmd_pkg.sv
lcd_message_rom.sv
lcd_power_on.sv
lcd_nibble_writer.sv
lcd_sequencer.sv
lcd_driver.sv
tb_lcd_driver.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LCD driver testbench with Verilator

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_lcd_driver -f list.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vtb_lcd_driver | tee "$log_file"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
	echo "Simulation did not run to completion"
	exit 1
fi

if grep -q "ERRORS FOUND" "$log_file"; then
	echo "Result: failing checks in $log_file"
	exit 1
fi
echo "Result: clean run"
exit 0

// ==== tb_lcd_driver.sv ====
`timescale 1ns/1ps

module tb_lcd_driver;

	////////////////////////////////////////
	// Limits and record types
	////////////////////////////////////////

	localparam int TEXT_START = 9;		// Entry of the first line-1 character
	localparam int TOTAL_ENTRIES = TEXT_START + lcd_cmd_pkg::LINE_1_LENGTH + 1
		+ lcd_cmd_pkg::LINE_2_LENGTH;
	localparam int RUN_LIMIT = 2_000_000;	// Whole message is about 1.1M cycles
	localparam int QUIET_CYCLES = 6000;	// Bus must stay idle after display_done
	localparam int TEXT_WINDOW = 40000;	// Reset point inside the text phase

	typedef struct packed {
		logic is_byte;
		logic [7:0] value;		// Bare nibbles sit in the upper half
		logic rs;
		logic [31:0] min_wait;	// Enable low cycles before the next entry
	} bus_entry_t;

	typedef struct packed {
		logic [3:0] data;
		logic rs;
		logic [31:0] gap;		// Enable low cycles before this pulse
	} pulse_t;

	logic clock = 1'b0;
	logic reset;
	lcd_cmd_pkg::lcd_nibble_t lcd_data;
	logic lcd_rs;
	logic lcd_e;
	logic display_done;

	pulse_t pulse_queue[$];	// Monitor to compare
	int entry;			// Next expected entry
	int half;			// 1 while waiting for a lower nibble
	int errors [1:5];		// Check failures per test
	int total_errors;
	int tests_run;
	int tests_failed;
	int unsigned seed_value;
	string stalled_on;
	bit ok;

	lcd_driver DUT (
		.clock(clock),
		.reset(reset),
		.lcd_data(lcd_data),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e),
		.display_done(display_done)
	);

	always #5 clock = ~clock;	// 10 ns period

	////////////////////////////////////////
	// Reference sequence
	////////////////////////////////////////

	// Strings hold the first character in the top byte
	function automatic logic [7:0] text_char(input logic line, input int unsigned column);
		logic [8*lcd_cmd_pkg::LINE_1_LENGTH-1:0] line_1;
		logic [8*lcd_cmd_pkg::LINE_2_LENGTH-1:0] line_2;
		line_1 = lcd_cmd_pkg::LINE_1_TEXT << (8 * column);	// Wanted character to the top
		line_2 = lcd_cmd_pkg::LINE_2_TEXT << (8 * column);
		if (!line)
			return line_1[8*lcd_cmd_pkg::LINE_1_LENGTH-1 -: 8];
		return line_2[8*lcd_cmd_pkg::LINE_2_LENGTH-1 -: 8];
	endfunction

	function automatic bus_entry_t expected_entry(input int n);
		bus_entry_t e;
		e.is_byte = 1'b1;
		e.rs = 1'b0;
		e.value = 8'h00;
		e.min_wait = 32'(lcd_timing_pkg::COMMAND_GAP_CYCLES);
		if (n < 4) begin		// Power-on nibbles
			e.is_byte = 1'b0;
			e.value = {(n == 3) ? lcd_cmd_pkg::INIT_NIBBLE_FOUR_BIT
				: lcd_cmd_pkg::INIT_NIBBLE_WAKE, 4'h0};
			case (n)
				0: e.min_wait = 32'(lcd_timing_pkg::WAIT_1_CYCLES);
				1: e.min_wait = 32'(lcd_timing_pkg::WAIT_2_CYCLES);
				default: e.min_wait = 32'(lcd_timing_pkg::WAIT_SHORT_CYCLES);
			endcase
		end else if (n < TEXT_START) begin
			case (n)
				4: e.value = lcd_cmd_pkg::CMD_FUNCTION_SET;
				5: e.value = lcd_cmd_pkg::CMD_ENTRY_MODE;
				6: e.value = lcd_cmd_pkg::CMD_DISPLAY_ON;
				7: begin
					e.value = lcd_cmd_pkg::CMD_CLEAR;
					e.min_wait = 32'(lcd_timing_pkg::CLEAR_CYCLES);	// Clear executes long
				end
				default: e.value = lcd_cmd_pkg::CMD_LINE_1_ADDR;
			endcase
		end else if (n < TEXT_START + lcd_cmd_pkg::LINE_1_LENGTH) begin
			e.value = text_char(1'b0, n - TEXT_START);
			e.rs = 1'b1;
		end else if (n == TEXT_START + lcd_cmd_pkg::LINE_1_LENGTH) begin
			e.value = lcd_cmd_pkg::CMD_LINE_2_ADDR;
		end else begin
			e.value = text_char(1'b1, n - TEXT_START - lcd_cmd_pkg::LINE_1_LENGTH - 1);
			e.rs = 1'b1;
		end
		return e;
	endfunction

	////////////////////////////////////////
	// Bus monitor, falling clock edge
	////////////////////////////////////////

	always @(negedge clock) begin : watch_bus
		logic prev_e;
		logic [3:0] prev_data;
		logic prev_rs;
		int low_count;
		int high_count;
		int stable_count;		// Samples with unchanged data and rs
		if (reset) begin
			prev_e = 1'b0;
			prev_data = lcd_data;
			prev_rs = lcd_rs;
			low_count = 0;
			high_count = 0;
			stable_count = 0;
		end else begin
			if (lcd_data == prev_data && lcd_rs == prev_rs) begin
				stable_count++;
			end else begin
				stable_count = 1;
				assert (!prev_e) else begin	// Includes the fall sample
					$display("FAIL %0t: lcd_data or lcd_rs changed while lcd_e high", $time);
					errors[4]++;
				end
			end
			if (lcd_e && !prev_e) begin	// Rising enable
				assert (stable_count > int'(lcd_timing_pkg::SETUP_CYCLES)) else begin
					$display("FAIL %0t: data stable %0d cycles at enable rise", $time,
						stable_count - 1);
					errors[4]++;
				end
				pulse_queue.push_back(pulse_t'{data: lcd_data, rs: lcd_rs, gap: 32'(low_count)});
				high_count = 1;
			end else if (lcd_e) begin
				high_count++;
			end else if (prev_e) begin	// Falling enable
				assert (high_count == int'(lcd_timing_pkg::ENABLE_CYCLES)) else begin
					$display("FAIL %0t: enable high for %0d cycles", $time, high_count);
					errors[4]++;
				end
				low_count = 1;
			end else begin
				low_count++;
			end
			prev_e = lcd_e;
			prev_data = lcd_data;
			prev_rs = lcd_rs;
		end
	end

	////////////////////////////////////////
	// Compare against the reference
	////////////////////////////////////////

	always @(posedge clock) begin : compare_bus
		pulse_t p;
		bus_entry_t exp;
		bus_entry_t prev;
		logic [31:0] need;
		logic [3:0] nibble;
		int test_id;
		if (reset) begin
			entry = 0;
			half = 0;
			pulse_queue.delete();	// Drop a half-seen byte
		end else begin
			while (pulse_queue.size() > 0) begin
				p = pulse_queue.pop_front();
				assert (entry < TOTAL_ENTRIES) else begin
					$display("FAIL %0t: extra enable pulse after the message, data %h",
						$time, p.data);
					errors[3]++;
				end
				if (entry < TOTAL_ENTRIES) begin
					exp = expected_entry(entry);
					test_id = (entry < 4) ? 1 : (entry < TEXT_START) ? 2 : 3;
					if (half == 0) begin
						need = 32'(lcd_timing_pkg::POWER_UP_CYCLES);	// From reset release
						if (entry > 0) begin
							prev = expected_entry(entry - 1);
							need = prev.min_wait;
						end
						nibble = exp.value[7:4];	// Upper nibble first
					end else begin
						need = 32'(lcd_timing_pkg::NIBBLE_GAP_CYCLES);
						nibble = exp.value[3:0];
					end
					assert (p.gap >= need) else begin
						$display("FAIL %0t: entry %0d enable low %0d cycles, need %0d", $time,
							entry, p.gap, need);
						errors[(entry < 4) ? 1 : 4]++;
					end
					assert (p.data == nibble && p.rs == exp.rs) else begin
						$display("FAIL %0t: entry %0d half %0d got %h rs %b, expected %h rs %b",
							$time, entry, half, p.data, p.rs, nibble, exp.rs);
						errors[test_id]++;
					end
					if (exp.is_byte && half == 0) begin
						half = 1;
					end else begin
						half = 0;
						entry++;
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;				// Drive point after the edge
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		wait_cycles(10);
		reset = 1'b0;
	endtask

	task automatic wait_for_display_done(output bit seen);
		int count;
		count = 0;
		while (!display_done && count < RUN_LIMIT) begin
			wait_cycles(1);
			count++;
		end
		seen = display_done;
		if (!seen) stalled_on = "display_done";
	endtask

	task automatic wait_for_entry(input int target, output bit seen);
		int count;
		count = 0;
		while (entry < target && count < RUN_LIMIT) begin
			wait_cycles(1);
			count++;
		end
		seen = (entry >= target);
		if (!seen) stalled_on = "the line-1 address byte";
	endtask

	task automatic report_test(input int id, input string name);
		tests_run++;
		if (errors[id] != 0) tests_failed++;
		$display("Test %0d %s: %s with %0d check failures", id, name,
			(errors[id] == 0) ? "passed" : "failed", errors[id]);
		total_errors += errors[id];
		errors[id] = 0;
	endtask

	// Tests 1 to 4 from reset release to an idle bus
	task automatic run_message(output bit finished);
		wait_for_display_done(finished);
		if (!finished) return;
		wait_cycles(QUIET_CYCLES);
		assert (entry == TOTAL_ENTRIES && half == 0 && display_done) else begin
			$display("FAIL %0t: %0d of %0d entries seen at the end", $time,
				entry, TOTAL_ENTRIES);
			errors[3]++;
		end
		report_test(1, "power-on nibbles");
		report_test(2, "setup commands");
		report_test(3, "message text");
		report_test(4, "bus timing");
	endtask

	// Test 5, reset at a random cycle of the text phase
	task automatic reset_mid_text(output bit finished);
		int delay;
		apply_reset();
		wait_for_entry(TEXT_START, finished);
		if (!finished) return;
		delay = 1 + int'($urandom % TEXT_WINDOW);
		wait_cycles(delay);
		reset = 1'b1;
		wait_cycles(1);
		assert (!lcd_e && !lcd_rs && lcd_data == '0 && !display_done) else begin
			$display("FAIL %0t: reset left e %b rs %b data %h done %b", $time,
				lcd_e, lcd_rs, lcd_data, display_done);
			errors[5]++;
		end
		wait_cycles(9);
		reset = 1'b0;
		report_test(5, "reset in text phase");
	endtask

	task automatic run_all(output bit finished);
		apply_reset();
		run_message(finished);
		if (!finished) return;
		reset_mid_text(finished);
		if (!finished) return;
		run_message(finished);	// Full sequence again after the reset
	endtask

	initial begin : main
		reset = 1'b1;
		seed_value = $urandom(32'hb65d_0e9a);
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		stalled_on = "";
		foreach (errors[i]) errors[i] = 0;
		run_all(ok);
		if (!ok) $display("Run stopped: timed out waiting for %s", stalled_on);
		foreach (errors[i]) total_errors += errors[i];	// Tests cut short by a timeout
		$display("Summary: %0d tests run, %0d failed, %0d check failures",
			tests_run, tests_failed, total_errors);
		if (ok && total_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== lcd_driver.sv ====
`timescale 1ns/1ps

module lcd_driver (
	input logic clock,
	input logic reset,
	output lcd_cmd_pkg::lcd_nibble_t lcd_data,	// DB7..DB4
	output logic lcd_rs,
	output logic lcd_e,
	output logic display_done			// Whole message written
);

	// Sequencer to writer
	logic start_byte;
	logic start_nibble;
	lcd_cmd_pkg::lcd_byte_t tx_byte;
	logic tx_rs;

	// Writer back to sequencer
	logic busy;
	logic done;

	lcd_sequencer sequencer (
		.clock(clock),
		.reset(reset),
		.busy(busy),
		.done(done),
		.start_byte(start_byte),
		.start_nibble(start_nibble),
		.tx_byte(tx_byte),
		.tx_rs(tx_rs),
		.display_done(display_done)
	);

	lcd_nibble_writer writer (
		.clock(clock),
		.reset(reset),
		.start_byte(start_byte),
		.start_nibble(start_nibble),
		.tx_byte(tx_byte),
		.tx_rs(tx_rs),
		.busy(busy),
		.done(done),
		.lcd_data(lcd_data),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e)
	);

endmodule

// ==== lcd_sequencer.sv ====
`timescale 1ns/1ps

module lcd_sequencer (
	input logic clock,
	input logic reset,
	input logic busy,				// Writer has a transfer in flight
	input logic done,				// Writer finished a transfer
	output logic start_byte,
	output logic start_nibble,
	output lcd_cmd_pkg::lcd_byte_t tx_byte,
	output logic tx_rs,				// High for characters only
	output logic display_done
);

	lcd_cmd_pkg::sequencer_state_t state;
	lcd_timing_pkg::cycle_count_t clear_count;	// Clear execution wait
	lcd_cmd_pkg::char_index_t column;
	lcd_cmd_pkg::lcd_byte_t char_code;
	lcd_cmd_pkg::lcd_nibble_t nibble;
	logic issued;					// Byte of this state already requested
	logic nibble_req;
	logic ready;
	logic rom_line;
	logic byte_state;				// State sends a byte

	lcd_power_on power_on (
		.clock(clock),
		.reset(reset),
		.writer_done(done),
		.nibble_req(nibble_req),
		.nibble(nibble),
		.ready(ready)
	);

	lcd_message_rom message_rom (
		.line(rom_line),
		.column(column),
		.char_code(char_code)
	);

	assign rom_line = (state == lcd_cmd_pkg::SEQ_LINE_2_TEXT);

	////////////////////////////////////////
	// Byte and rs for each state
	////////////////////////////////////////

	always_comb begin
		byte_state = 1'b1;
		tx_rs = 1'b0;
		case (state)
			lcd_cmd_pkg::SEQ_POWER_ON: begin
				byte_state = 1'b0;
				tx_byte = {nibble, 4'h0};	// Writer sends the upper half
			end
			lcd_cmd_pkg::SEQ_FUNCTION_SET: tx_byte = lcd_cmd_pkg::CMD_FUNCTION_SET;
			lcd_cmd_pkg::SEQ_ENTRY_MODE: tx_byte = lcd_cmd_pkg::CMD_ENTRY_MODE;
			lcd_cmd_pkg::SEQ_DISPLAY_ON: tx_byte = lcd_cmd_pkg::CMD_DISPLAY_ON;
			lcd_cmd_pkg::SEQ_CLEAR: tx_byte = lcd_cmd_pkg::CMD_CLEAR;
			lcd_cmd_pkg::SEQ_LINE_1_ADDR: tx_byte = lcd_cmd_pkg::CMD_LINE_1_ADDR;
			lcd_cmd_pkg::SEQ_LINE_2_ADDR: tx_byte = lcd_cmd_pkg::CMD_LINE_2_ADDR;
			lcd_cmd_pkg::SEQ_LINE_1_TEXT,
			lcd_cmd_pkg::SEQ_LINE_2_TEXT: begin
				tx_byte = char_code;
				tx_rs = 1'b1;		// Data register
			end
			default: begin			// Clear wait and done
				byte_state = 1'b0;
				tx_byte = '0;
			end
		endcase
	end

	// Power-on nibbles pass through only before the commands
	assign start_nibble = (state == lcd_cmd_pkg::SEQ_POWER_ON) && nibble_req && !busy;
	assign start_byte = byte_state && !issued && !busy;
	assign display_done = (state == lcd_cmd_pkg::SEQ_DONE);

	////////////////////////////////////////
	// Script FSM
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lcd_cmd_pkg::SEQ_POWER_ON;
			issued <= 1'b0;
			column <= '0;
			clear_count <= '0;
		end else begin
			if (start_byte) issued <= 1'b1;
			if (done) issued <= 1'b0;	// Next byte requested next cycle
			case (state)
				lcd_cmd_pkg::SEQ_POWER_ON:
					if (ready) state <= lcd_cmd_pkg::SEQ_FUNCTION_SET;
				lcd_cmd_pkg::SEQ_FUNCTION_SET:
					if (done) state <= lcd_cmd_pkg::SEQ_ENTRY_MODE;
				lcd_cmd_pkg::SEQ_ENTRY_MODE:
					if (done) state <= lcd_cmd_pkg::SEQ_DISPLAY_ON;
				lcd_cmd_pkg::SEQ_DISPLAY_ON:
					if (done) state <= lcd_cmd_pkg::SEQ_CLEAR;
				lcd_cmd_pkg::SEQ_CLEAR: begin
					if (done) begin
						clear_count <= lcd_timing_pkg::CLEAR_CYCLES - 1'b1;
						state <= lcd_cmd_pkg::SEQ_CLEAR_WAIT;
					end
				end
				lcd_cmd_pkg::SEQ_CLEAR_WAIT: begin
					if (clear_count == '0) state <= lcd_cmd_pkg::SEQ_LINE_1_ADDR;
					else clear_count <= clear_count - 1'b1;
				end
				lcd_cmd_pkg::SEQ_LINE_1_ADDR:
					if (done) state <= lcd_cmd_pkg::SEQ_LINE_1_TEXT;
				lcd_cmd_pkg::SEQ_LINE_1_TEXT: begin
					if (done) begin
						if (column == lcd_cmd_pkg::char_index_t'(lcd_cmd_pkg::LINE_1_LENGTH - 1)) begin
							column <= '0;
							state <= lcd_cmd_pkg::SEQ_LINE_2_ADDR;
						end else begin
							column <= column + 1'b1;
						end
					end
				end
				lcd_cmd_pkg::SEQ_LINE_2_ADDR:
					if (done) state <= lcd_cmd_pkg::SEQ_LINE_2_TEXT;
				lcd_cmd_pkg::SEQ_LINE_2_TEXT: begin
					if (done) begin
						if (column == lcd_cmd_pkg::char_index_t'(lcd_cmd_pkg::LINE_2_LENGTH - 1)) begin
							column <= '0;
							state <= lcd_cmd_pkg::SEQ_DONE;
						end else begin
							column <= column + 1'b1;
						end
					end
				end
				lcd_cmd_pkg::SEQ_DONE: state <= lcd_cmd_pkg::SEQ_DONE;	// Text stays up
				default: state <= lcd_cmd_pkg::SEQ_POWER_ON;
			endcase
		end
	end

endmodule

// ==== lcd_nibble_writer.sv ====
`timescale 1ns/1ps

module lcd_nibble_writer (
	input logic clock,
	input logic reset,
	input logic start_byte,			// Two nibbles plus command gap
	input logic start_nibble,			// Upper half of tx_byte only
	input lcd_cmd_pkg::lcd_byte_t tx_byte,
	input logic tx_rs,
	output logic busy,
	output logic done,				// One cycle at the end
	output lcd_cmd_pkg::lcd_nibble_t lcd_data,
	output logic lcd_rs,
	output logic lcd_e
);

	lcd_cmd_pkg::writer_state_t state;
	lcd_timing_pkg::bus_count_t count;		// Shared by every phase
	lcd_cmd_pkg::lcd_nibble_t lower_nibble;	// Held for the second half
	logic nibble_mode;
	logic second_half;
	logic accept;

	assign busy = (state != lcd_cmd_pkg::WR_IDLE);
	assign accept = !busy && (start_byte || start_nibble);

	// Lower half of the byte, kept while the upper half goes out
	always_ff @(posedge clock) begin
		if (accept) lower_nibble <= tx_byte[3:0];
	end

	////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lcd_cmd_pkg::WR_IDLE;
			count <= '0;
			nibble_mode <= 1'b0;
			second_half <= 1'b0;
			done <= 1'b0;
			lcd_data <= '0;
			lcd_rs <= 1'b0;
			lcd_e <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				lcd_cmd_pkg::WR_IDLE: begin
					if (accept) begin
						lcd_data <= tx_byte[7:4];	// Upper nibble first
						lcd_rs <= tx_rs;
						nibble_mode <= start_nibble;
						second_half <= 1'b0;
						count <= lcd_timing_pkg::SETUP_CYCLES - 1'b1;
						state <= lcd_cmd_pkg::WR_SETUP;
					end
				end

				lcd_cmd_pkg::WR_SETUP: begin	// Data settles before enable
					if (count == '0) begin
						lcd_e <= 1'b1;
						count <= lcd_timing_pkg::ENABLE_CYCLES - 1'b1;
						state <= lcd_cmd_pkg::WR_ENABLE;
					end else begin
						count <= count - 1'b1;
					end
				end

				lcd_cmd_pkg::WR_ENABLE: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else begin
						lcd_e <= 1'b0;
						if (nibble_mode) begin
							done <= 1'b1;	// Bare nibble ends here
							state <= lcd_cmd_pkg::WR_IDLE;
						end else if (!second_half) begin
							count <= lcd_timing_pkg::NIBBLE_GAP_CYCLES - 1'b1;
							state <= lcd_cmd_pkg::WR_NIBBLE_GAP;
						end else begin
							count <= lcd_timing_pkg::COMMAND_GAP_CYCLES - 1'b1;
							state <= lcd_cmd_pkg::WR_COMMAND_GAP;
						end
					end
				end

				lcd_cmd_pkg::WR_NIBBLE_GAP: begin	// Enable low between halves
					if (count == '0) begin
						lcd_data <= lower_nibble;
						second_half <= 1'b1;
						count <= lcd_timing_pkg::SETUP_CYCLES - 1'b1;
						state <= lcd_cmd_pkg::WR_SETUP;
					end else begin
						count <= count - 1'b1;
					end
				end

				lcd_cmd_pkg::WR_COMMAND_GAP: begin	// Display executes the byte
					if (count == '0) begin
						done <= 1'b1;
						state <= lcd_cmd_pkg::WR_IDLE;
					end else begin
						count <= count - 1'b1;
					end
				end

				default: state <= lcd_cmd_pkg::WR_IDLE;
			endcase
		end
	end

endmodule

// ==== lcd_power_on.sv ====
`timescale 1ns/1ps

module lcd_power_on (
	input logic clock,
	input logic reset,
	input logic writer_done,			// Nibble finished on the bus
	output logic nibble_req,			// One-cycle request
	output lcd_cmd_pkg::lcd_nibble_t nibble,
	output logic ready				// Held once the sequence ends
);

	lcd_cmd_pkg::power_on_state_t state;
	lcd_timing_pkg::cycle_count_t count;	// Down counter for all waits
	lcd_timing_pkg::cycle_count_t wait_cycles;	// Wait after the current nibble
	logic [1:0] step;				// Which of the four nibbles

	////////////////////////////////////////
	// Per-step nibble and wait
	////////////////////////////////////////

	always_comb begin
		case (step)
			2'd0: wait_cycles = lcd_timing_pkg::WAIT_1_CYCLES;
			2'd1: wait_cycles = lcd_timing_pkg::WAIT_2_CYCLES;
			default: wait_cycles = lcd_timing_pkg::WAIT_SHORT_CYCLES;	// Steps 2 and 3
		endcase
	end

	// Three wake nibbles, then switch to 4-bit
	assign nibble = (step == 2'd3) ? lcd_cmd_pkg::INIT_NIBBLE_FOUR_BIT
		: lcd_cmd_pkg::INIT_NIBBLE_WAKE;

	assign nibble_req = (state == lcd_cmd_pkg::PO_REQUEST);
	assign ready = (state == lcd_cmd_pkg::PO_READY);

	////////////////////////////////////////
	// Sequence FSM
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lcd_cmd_pkg::PO_POWER_UP;
			count <= lcd_timing_pkg::POWER_UP_CYCLES - 1'b1;	// Starts at release
			step <= 2'd0;
		end else begin
			case (state)
				lcd_cmd_pkg::PO_POWER_UP: begin
					if (count == '0) begin
						state <= lcd_cmd_pkg::PO_REQUEST;
					end else begin
						count <= count - 1'b1;
					end
				end

				lcd_cmd_pkg::PO_REQUEST: begin
					state <= lcd_cmd_pkg::PO_TRANSFER;	// Writer is idle here
				end

				lcd_cmd_pkg::PO_TRANSFER: begin
					if (writer_done) begin	// Wait counts from done
						count <= wait_cycles - 1'b1;
						state <= lcd_cmd_pkg::PO_WAIT;
					end
				end

				lcd_cmd_pkg::PO_WAIT: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else if (step == 2'd3) begin
						state <= lcd_cmd_pkg::PO_READY;	// Last wait over
					end else begin
						step <= step + 1'b1;
						state <= lcd_cmd_pkg::PO_REQUEST;
					end
				end

				lcd_cmd_pkg::PO_READY: state <= lcd_cmd_pkg::PO_READY;

				default: state <= lcd_cmd_pkg::PO_POWER_UP;
			endcase
		end
	end

endmodule

// ==== lcd_message_rom.sv ====
`timescale 1ns/1ps

module lcd_message_rom (
	input logic line,				// 0 is the top line
	input lcd_cmd_pkg::char_index_t column,
	output lcd_cmd_pkg::lcd_byte_t char_code
);

	int unsigned offset;	// Bit position of the selected byte

	// Both strings hold the first character in the top byte,
	// so the column counts down from the high end
	always_comb begin
		offset = 0;
		char_code = '0;
		if (!line) begin
			if (column < lcd_cmd_pkg::LINE_1_LENGTH) begin
				offset = 8 * (lcd_cmd_pkg::LINE_1_LENGTH - 1 - column);
				char_code = lcd_cmd_pkg::LINE_1_TEXT[offset +: 8];
			end
		end else begin
			if (column < lcd_cmd_pkg::LINE_2_LENGTH) begin
				offset = 8 * (lcd_cmd_pkg::LINE_2_LENGTH - 1 - column);
				char_code = lcd_cmd_pkg::LINE_2_TEXT[offset +: 8];
			end
		end
	end

endmodule

// ==== lcd_cmd_pkg.sv ====
package lcd_cmd_pkg;

	typedef logic [7:0] lcd_byte_t;	// Full command or character
	typedef logic [3:0] lcd_nibble_t;	// DB7..DB4 on the bus
	typedef logic [3:0] char_index_t;	// Column within a line

	////////////////////////////////////////
	// Command bytes
	////////////////////////////////////////

	localparam lcd_byte_t CMD_FUNCTION_SET = 8'h28;	// 4-bit, 2 lines, 5x8 font
	localparam lcd_byte_t CMD_ENTRY_MODE = 8'h06;		// Increment, no shift
	localparam lcd_byte_t CMD_DISPLAY_ON = 8'h0C;		// Display on, cursor off
	localparam lcd_byte_t CMD_CLEAR = 8'h01;
	localparam lcd_byte_t CMD_LINE_1_ADDR = 8'h80;	// DDRAM address 0x00
	localparam lcd_byte_t CMD_LINE_2_ADDR = 8'hC0;	// DDRAM address 0x40

	// Bare nibbles of the power-on sequence
	localparam lcd_nibble_t INIT_NIBBLE_WAKE = 4'h3;
	localparam lcd_nibble_t INIT_NIBBLE_FOUR_BIT = 4'h2;

	////////////////////////////////////////
	// Message text
	////////////////////////////////////////

	localparam int unsigned LINE_1_LENGTH = 13;
	localparam int unsigned LINE_2_LENGTH = 12;

	// First character sits in the top byte
	localparam logic [8*LINE_1_LENGTH-1:0] LINE_1_TEXT = "FPGA Lab 2012";
	localparam logic [8*LINE_2_LENGTH-1:0] LINE_2_TEXT = "Enjoying It!";

	////////////////////////////////////////
	// State machines
	////////////////////////////////////////

	typedef enum logic [2:0] {
		PO_POWER_UP,	// Initial 15 ms
		PO_REQUEST,	// Ask for one nibble
		PO_TRANSFER,	// Nibble on the bus
		PO_WAIT,	// Wait after the nibble
		PO_READY
	} power_on_state_t;

	typedef enum logic [3:0] {
		SEQ_POWER_ON,
		SEQ_FUNCTION_SET,
		SEQ_ENTRY_MODE,
		SEQ_DISPLAY_ON,
		SEQ_CLEAR,
		SEQ_CLEAR_WAIT,
		SEQ_LINE_1_ADDR,
		SEQ_LINE_1_TEXT,
		SEQ_LINE_2_ADDR,
		SEQ_LINE_2_TEXT,
		SEQ_DONE
	} sequencer_state_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_SETUP,
		WR_ENABLE,
		WR_NIBBLE_GAP,
		WR_COMMAND_GAP
	} writer_state_t;

endpackage

// ==== lcd_timing_pkg.sv ====
package lcd_timing_pkg;

	////////////////////////////////////////
	// Counter types
	////////////////////////////////////////

	typedef logic [19:0] cycle_count_t;	// Long waits, up to 750,000
	typedef logic [10:0] bus_count_t;	// Bus phases, up to 2,000

	////////////////////////////////////////
	// Power-on waits at 50 MHz
	////////////////////////////////////////

	// 15 ms after power before the first nibble
	localparam cycle_count_t POWER_UP_CYCLES = 20'd750000;

	localparam cycle_count_t WAIT_1_CYCLES = 20'd205000;		// 4.1 ms
	localparam cycle_count_t WAIT_2_CYCLES = 20'd5000;		// 100 us
	localparam cycle_count_t WAIT_SHORT_CYCLES = 20'd2000;	// 40 us, third and fourth nibble

	// Clear display executes for 1.64 ms
	localparam cycle_count_t CLEAR_CYCLES = 20'd82000;

	////////////////////////////////////////
	// Bus phases at 50 MHz
	////////////////////////////////////////

	// Data and rs stable 40 ns before enable
	localparam bus_count_t SETUP_CYCLES = 11'd2;

	// Enable high 230 ns or longer
	localparam bus_count_t ENABLE_CYCLES = 11'd12;

	// 1 us between upper and lower nibble
	localparam bus_count_t NIBBLE_GAP_CYCLES = 11'd50;

	// 40 us after each byte
	localparam bus_count_t COMMAND_GAP_CYCLES = 11'd2000;

endpackage
